// ==== verilog.f ====
+incdir+include
rtl/alu_types_pkg.sv
rtl/axi_lite_pkg.sv
rtl/barrel_shifter.sv
rtl/arith_logic_unit.sv
rtl/result_select.sv
rtl/alu_axil_regs.sv
rtl/alu_axil_top.sv
verification/alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module alu_tb -f verilog.f -o alu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/alu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi

exit 0

// ==== verification/alu_tb.sv ====
`include "alu_params.svh"

module alu_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import alu_types_pkg::*;
	import axi_lite_pkg::*;

	localparam int TIMEOUT_CYCLES = 100;

	logic       clk;
	logic       arst_n;
	axi_addr_t  awaddr;
	logic       awvalid;
	logic       awready;
	data_word_t wdata;
	logic [3:0] wstrb;
	logic       wvalid;
	logic       wready;
	axi_resp_t  bresp;
	logic       bvalid;
	logic       bready;
	axi_addr_t  araddr;
	logic       arvalid;
	logic       arready;
	data_word_t rdata;
	axi_resp_t  rresp;
	logic       rvalid;
	logic       rready;

	int   errors;
	int   checks;
	logic timed_out;

	alu_axil_top i_alu_axil_top (
		.clk, .arst_n,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic timeout_error(input string what);
		$display("Timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
		errors++;
		timed_out = 1'b1;
	endtask

	//////////////////////////////
	// Bus transactions
	//////////////////////////////

	// Entered and left 1 ns after a rising edge
	// Hold keeps bready low that many cycles
	task automatic axi_write(input axi_addr_t addr, input data_word_t data, input int hold,
		output axi_resp_t resp);
		int n;
		resp = RESP_SLVERR;
		if (timed_out)
			return;
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!awready && n < TIMEOUT_CYCLES);
		if (!awready) begin
			timeout_error("awready");
			return;
		end
		// Address and data ready rise together
		check_value("wready", 32'(wready), 32'd1);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!bvalid && n < TIMEOUT_CYCLES);
		if (!bvalid) begin
			timeout_error("bvalid");
			return;
		end
		resp = bresp;
		repeat (hold) begin
			@(negedge clk);
			check_value("bvalid", 32'(bvalid), 32'd1);
			check_value("bresp", 32'(bresp), 32'(resp));
		end
		@(posedge clk);
		#1;
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, input int hold, output data_word_t data,
		output axi_resp_t resp);
		int n;
		data = '0;
		resp = RESP_SLVERR;
		if (timed_out)
			return;
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!arready && n < TIMEOUT_CYCLES);
		if (!arready) begin
			timeout_error("arready");
			return;
		end
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!rvalid && n < TIMEOUT_CYCLES);
		if (!rvalid) begin
			timeout_error("rvalid");
			return;
		end
		data = rdata;
		resp = rresp;
		// Data must not move while the host stalls
		repeat (hold) begin
			@(negedge clk);
			check_value("rvalid", 32'(rvalid), 32'd1);
			check_value("rdata", rdata, data);
			check_value("rresp", 32'(rresp), 32'(resp));
		end
		@(posedge clk);
		#1;
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	// Reference model of the operation set
	function automatic data_word_t expected_result(input logic [3:0] op, input data_word_t a,
		input data_word_t b);
		logic [4:0] sh;
		sh = b[4:0];
		case (op)
			OP_SLL:  return a << sh;
			OP_SRL:  return a >> sh;
			OP_SRA:  return $unsigned($signed(a) >>> sh);
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLT:  return {31'd0, $signed(a) < $signed(b)};
			OP_SLTU: return {31'd0, a < b};
			default: return 32'd0;
		endcase
	endfunction

	// One full operation, then poll STATUS and compare result and flags
	task automatic run_op(input logic [3:0] op, input data_word_t a, input data_word_t b);
		axi_resp_t  resp;
		data_word_t status;
		data_word_t res;
		data_word_t exp_res;
		data_word_t exp_status;
		int         polls;
		axi_write(`REG_OPERAND_A, a, 0, resp);
		check_value("bresp", 32'(resp), 32'(RESP_OKAY));
		axi_write(`REG_OPERAND_B, b, 0, resp);
		check_value("bresp", 32'(resp), 32'(RESP_OKAY));
		axi_write(`REG_OPCODE, {28'd0, op}, 0, resp);
		check_value("bresp", 32'(resp), 32'(RESP_OKAY));
		polls  = 0;
		status = '0;
		do begin
			axi_read(`REG_STATUS, 0, status, resp);
			polls++;
		end while (!status[`STATUS_VALID_BIT] && polls < TIMEOUT_CYCLES && !timed_out);
		if (timed_out)
			return;
		if (!status[`STATUS_VALID_BIT]) begin
			timeout_error("valid bit in STATUS");
			return;
		end
		exp_res    = expected_result(op, a, b);
		exp_status = '0;
		exp_status[`STATUS_VALID_BIT]  = 1'b1;
		exp_status[`STATUS_ZERO_BIT]   = (exp_res == 32'd0);
		exp_status[`STATUS_NEG_BIT]    = exp_res[31];
		exp_status[`STATUS_BAD_OP_BIT] = (op > 4'd9);
		check_value("status", status, exp_status);
		axi_read(`REG_RESULT, 0, res, resp);
		check_value("rresp", 32'(resp), 32'(RESP_OKAY));
		check_value("result", res, exp_res);
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic reset_and_readback();
		axi_resp_t  resp;
		data_word_t data;
		axi_read(`REG_RESULT, 0, data, resp);
		check_value("result", data, 32'd0);
		check_value("rresp", 32'(resp), 32'(RESP_OKAY));
		axi_read(`REG_STATUS, 0, data, resp);
		check_value("status", data, 32'd0);
		check_value("rresp", 32'(resp), 32'(RESP_OKAY));
		axi_write(`REG_OPERAND_A, 32'hA5A5_0F0F, 0, resp);
		axi_write(`REG_OPERAND_B, 32'h1234_5678, 0, resp);
		axi_read(`REG_OPERAND_A, 0, data, resp);
		check_value("operand_a", data, 32'hA5A5_0F0F);
		axi_read(`REG_OPERAND_B, 0, data, resp);
		check_value("operand_b", data, 32'h1234_5678);
	endtask

	// Upper bits of B are random and must not matter
	task automatic shift_sweep();
		data_word_t patterns [4];
		data_word_t b;
		patterns[0] = 32'h8000_0001;
		patterns[1] = 32'hF0F0_1234;
		patterns[2] = 32'h7654_3210;
		patterns[3] = 32'hFFFF_FFFF;
		for (int p = 0; p < 4; p++) begin
			for (int op = 0; op < 3; op++) begin
				for (int amt = 0; amt < 32; amt++) begin
					b = $urandom();
					b[4:0] = amt[4:0];
					run_op(op[3:0], patterns[p], b);
				end
			end
		end
	endtask

	task automatic arith_logic_sweep();
		data_word_t corner_a [7];
		data_word_t corner_b [7];
		data_word_t a;
		data_word_t b;
		corner_a = '{32'h7FFF_FFFF, 32'h8000_0000, 32'h8000_0000, 32'hFFFF_FFFF,
			32'h1234_5678, 32'h0000_0000, 32'h8000_0000};
		corner_b = '{32'h0000_0001, 32'h8000_0000, 32'h0000_0001, 32'h0000_0001,
			32'h1234_5678, 32'h0000_0000, 32'h7FFF_FFFF};
		for (int i = 0; i < 40; i++) begin
			a = $urandom();
			b = $urandom();
			for (int op = 3; op < 10; op++)
				run_op(op[3:0], a, b);
		end
		// Overflow and equal operands
		for (int i = 0; i < 7; i++) begin
			for (int op = 3; op < 10; op++)
				run_op(op[3:0], corner_a[i], corner_b[i]);
		end
	endtask

	task automatic undefined_opcodes();
		for (int op = 10; op < 16; op++)
			run_op(op[3:0], $urandom(), $urandom());
	endtask

	task automatic protocol_errors();
		axi_resp_t  resp;
		data_word_t data;
		run_op(OP_XOR, 32'h1111_2222, 32'h3333_4444);
		axi_write(`REG_RESULT, 32'hDEAD_BEEF, 0, resp);
		check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
		axi_write(`REG_STATUS, 32'hDEAD_BEEF, 0, resp);
		check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
		axi_write(8'h1C, 32'hDEAD_BEEF, 0, resp);
		check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
		axi_read(`REG_OPERAND_A, 0, data, resp);
		check_value("operand_a", data, 32'h1111_2222);
		axi_read(`REG_OPERAND_B, 0, data, resp);
		check_value("operand_b", data, 32'h3333_4444);
		axi_read(`REG_RESULT, 0, data, resp);
		check_value("result", data, 32'h2222_6666);
		axi_read(`REG_STATUS, 0, data, resp);
		check_value("status", data, 32'h0000_0001);
		axi_read(8'h1C, 0, data, resp);
		check_value("rresp", 32'(resp), 32'(RESP_SLVERR));
		check_value("rdata", data, 32'd0);
	endtask

	task automatic back_pressure();
		axi_resp_t  resp;
		data_word_t data;
		axi_write(`REG_OPERAND_A, 32'h0BAD_F00D, 6, resp);
		check_value("bresp", 32'(resp), 32'(RESP_OKAY));
		axi_read(`REG_OPERAND_A, 6, data, resp);
		check_value("rresp", 32'(resp), 32'(RESP_OKAY));
		check_value("operand_a", data, 32'h0BAD_F00D);
		axi_write(8'h1C, 32'h0, 4, resp);
		check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
	endtask

	initial begin
		void'($urandom(32'h4d7b));
		errors    = 0;
		checks    = 0;
		timed_out = 1'b0;
		clk       = 1'b0;
		arst_n    = 1'b0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = 4'hF;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;

		reset_and_readback();
		shift_sweep();
		arith_logic_sweep();
		undefined_opcodes();
		protocol_errors();
		back_pressure();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== rtl/alu_axil_top.sv ====
`include "alu_params.svh"

module alu_axil_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  axi_lite_pkg::axi_addr_t   awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  alu_types_pkg::data_word_t wdata,
	input  logic [`DATA_WIDTH/8-1:0]  wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output axi_lite_pkg::axi_resp_t   bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  axi_lite_pkg::axi_addr_t   araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output alu_types_pkg::data_word_t rdata,
	output axi_lite_pkg::axi_resp_t   rresp,
	output logic                      rvalid,
	input  logic                      rready
);

	import alu_types_pkg::*;

	// Register block to datapath
	data_word_t operand_a;
	data_word_t operand_b;
	alu_op_t    opcode;
	logic       start;

	// Unit outputs
	data_word_t shift_result;
	data_word_t arith_result;

	// Registered result and flags
	data_word_t result;
	logic       res_valid;
	logic       res_zero;
	logic       res_neg;
	logic       res_bad_op;

	alu_axil_regs i_alu_axil_regs (
		.clk, .arst_n,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.operand_a, .operand_b, .opcode, .start,
		.result, .res_valid, .res_zero, .res_neg, .res_bad_op
	);

	barrel_shifter i_barrel_shifter (
		.operand_a, .operand_b, .opcode, .shift_result
	);

	arith_logic_unit i_arith_logic_unit (
		.operand_a, .operand_b, .opcode, .arith_result
	);

	result_select i_result_select (
		.clk, .arst_n, .start, .opcode, .shift_result, .arith_result,
		.result, .res_valid, .res_zero, .res_neg, .res_bad_op
	);

endmodule

// ==== rtl/alu_axil_regs.sv ====
`include "alu_params.svh"

module alu_axil_regs (
	input  logic                      clk,
	input  logic                      arst_n,
	// Write address
	input  axi_lite_pkg::axi_addr_t   awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	// Write data
	input  alu_types_pkg::data_word_t wdata,
	input  logic [`DATA_WIDTH/8-1:0]  wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	// Write response
	output axi_lite_pkg::axi_resp_t   bresp,
	output logic                      bvalid,
	input  logic                      bready,
	// Read address
	input  axi_lite_pkg::axi_addr_t   araddr,
	input  logic                      arvalid,
	output logic                      arready,
	// Read data
	output alu_types_pkg::data_word_t rdata,
	output axi_lite_pkg::axi_resp_t   rresp,
	output logic                      rvalid,
	input  logic                      rready,
	// Datapath side
	output alu_types_pkg::data_word_t operand_a,
	output alu_types_pkg::data_word_t operand_b,
	output alu_types_pkg::alu_op_t    opcode,
	output logic                      start,
	input  alu_types_pkg::data_word_t result,
	input  logic                      res_valid,
	input  logic                      res_zero,
	input  logic                      res_neg,
	input  logic                      res_bad_op
);

	import alu_types_pkg::*;
	import axi_lite_pkg::*;

	wr_state_t  wr_state;
	rd_state_t  rd_state;
	logic       wr_fire;
	logic       wr_mapped;
	logic       rd_fire;
	logic       rd_mapped;
	data_word_t status_word;
	data_word_t rd_word;

	//////////////////////////////
	// Write channel
	//////////////////////////////

	// Address and data are taken together, wstrb is ignored (full-word writes)
	assign wr_fire   = (wr_state == WR_IDLE) && awvalid && wvalid;
	assign awready   = wr_fire;
	assign wready    = wr_fire;
	assign bvalid    = (wr_state == WR_RESP);
	assign wr_mapped = (awaddr == `REG_OPERAND_A) || (awaddr == `REG_OPERAND_B) ||
		(awaddr == `REG_OPCODE);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_state <= WR_IDLE;
			bresp    <= RESP_OKAY;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (wr_fire) begin
						wr_state <= WR_RESP;
						bresp    <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
					end
				end
				WR_RESP: begin
					if (bready)
						wr_state <= WR_IDLE;
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	// Operand and opcode registers
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			operand_a <= '0;
			operand_b <= '0;
			opcode    <= OP_SLL;
			start     <= 1'b0;
		end else begin
			// One cycle after the opcode write
			start <= wr_fire && (awaddr == `REG_OPCODE);
			if (wr_fire) begin
				case (awaddr)
					`REG_OPERAND_A: operand_a <= wdata;
					`REG_OPERAND_B: operand_b <= wdata;
					`REG_OPCODE:    opcode    <= alu_op_t'(wdata[$bits(alu_op_t)-1:0]);
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// Read channel
	//////////////////////////////
	always_comb begin
		status_word = '0;
		status_word[`STATUS_VALID_BIT]  = res_valid;
		status_word[`STATUS_ZERO_BIT]   = res_zero;
		status_word[`STATUS_NEG_BIT]    = res_neg;
		status_word[`STATUS_BAD_OP_BIT] = res_bad_op;
	end

	always_comb begin
		rd_mapped = 1'b1;
		case (araddr)
			`REG_OPERAND_A: rd_word = operand_a;
			`REG_OPERAND_B: rd_word = operand_b;
			`REG_OPCODE:    rd_word = data_word_t'(opcode);
			`REG_RESULT:    rd_word = result;
			`REG_STATUS:    rd_word = status_word;
			default: begin
				rd_word   = '0;
				rd_mapped = 1'b0;
			end
		endcase
	end

	assign rd_fire = (rd_state == RD_IDLE) && arvalid;
	assign arready = rd_fire;
	assign rvalid  = (rd_state == RD_DATA);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_state <= RD_IDLE;
			rdata    <= '0;
			rresp    <= RESP_OKAY;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (rd_fire) begin
						rd_state <= RD_DATA;
						rdata    <= rd_word;
						rresp    <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
					end
				end
				RD_DATA: begin
					if (rready)
						rd_state <= RD_IDLE;
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

endmodule

// ==== rtl/result_select.sv ====
`include "alu_params.svh"

module result_select (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      start,
	input  alu_types_pkg::alu_op_t    opcode,
	input  alu_types_pkg::data_word_t shift_result,
	input  alu_types_pkg::data_word_t arith_result,
	output alu_types_pkg::data_word_t result,
	output logic                      res_valid,
	output logic                      res_zero,
	output logic                      res_neg,
	output logic                      res_bad_op
);

	import alu_types_pkg::*;

	data_word_t sel_result;
	logic       sel_bad_op;
	logic       valid_q;

	// Opcode classes
	always_comb begin
		sel_bad_op = 1'b0;
		case (opcode)
			OP_SLL, OP_SRL, OP_SRA: sel_result = shift_result;
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
			OP_SLT, OP_SLTU:        sel_result = arith_result;
			default: begin
				sel_result = '0;
				sel_bad_op = 1'b1;
			end
		endcase
	end

	// Capture on the edge that ends the start cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result     <= '0;
			res_zero   <= 1'b0;
			res_neg    <= 1'b0;
			res_bad_op <= 1'b0;
			valid_q    <= 1'b0;
		end else if (start) begin
			result     <= sel_result;
			res_zero   <= (sel_result == '0);
			res_neg    <= sel_result[`DATA_WIDTH-1];
			res_bad_op <= sel_bad_op;
			valid_q    <= 1'b1;
		end
	end

	// Valid drops while start is high, so it reads 0 until the new capture
	assign res_valid = valid_q & ~start;

endmodule

// ==== rtl/arith_logic_unit.sv ====
`include "alu_params.svh"

module arith_logic_unit (
	input  alu_types_pkg::data_word_t operand_a,
	input  alu_types_pkg::data_word_t operand_b,
	input  alu_types_pkg::alu_op_t    opcode,
	output alu_types_pkg::data_word_t arith_result
);

	import alu_types_pkg::*;

	logic       subtract;
	data_word_t b_operand;
	data_word_t sum;
	logic       less_signed;
	logic       less_unsigned;

	//////////////////////////////
	// Shared adder
	//////////////////////////////

	// Subtract as A + ~B + 1
	assign subtract  = (opcode == OP_SUB);
	assign b_operand = subtract ? ~operand_b : operand_b;
	assign sum       = operand_a + b_operand + data_word_t'(subtract);

	// Compares
	assign less_signed   = $signed(operand_a) < $signed(operand_b);
	assign less_unsigned = operand_a < operand_b;

	//////////////////////////////
	// Output select
	//////////////////////////////
	always_comb begin
		case (opcode)
			OP_ADD,
			OP_SUB:  arith_result = sum;
			OP_AND:  arith_result = operand_a & operand_b;
			OP_OR:   arith_result = operand_a | operand_b;
			OP_XOR:  arith_result = operand_a ^ operand_b;
			OP_SLT:  arith_result = data_word_t'(less_signed);
			OP_SLTU: arith_result = data_word_t'(less_unsigned);
			// Shift and undefined codes are not ours
			default: arith_result = '0;
		endcase
	end

endmodule

// ==== rtl/barrel_shifter.sv ====
`include "alu_params.svh"

module barrel_shifter (
	input  alu_types_pkg::data_word_t operand_a,
	input  alu_types_pkg::data_word_t operand_b,
	input  alu_types_pkg::alu_op_t    opcode,
	output alu_types_pkg::data_word_t shift_result
);

	import alu_types_pkg::*;

	shamt_t     shamt;
	logic       shift_left;
	logic       fill_bit;
	data_word_t stage_data [`SHAMT_WIDTH+1];

	// Mirror the word so that one right-shift chain also does left shifts
	function automatic data_word_t reverse_bits(input data_word_t value);
		data_word_t reversed;
		for (int i = 0; i < `DATA_WIDTH; i++) begin
			reversed[i] = value[`DATA_WIDTH-1-i];
		end
		return reversed;
	endfunction

	assign shamt      = operand_b[`SHAMT_WIDTH-1:0];
	assign shift_left = (opcode == OP_SLL);

	// Sign fill only for arithmetic right
	assign fill_bit = (opcode == OP_SRA) ? operand_a[`DATA_WIDTH-1] : 1'b0;

	assign stage_data[0] = shift_left ? reverse_bits(operand_a) : operand_a;

	//////////////////////////////
	// Log stages 16 8 4 2 1
	//////////////////////////////
	for (genvar i = 0; i < `SHAMT_WIDTH; i++) begin : g_stage
		localparam int AMT_BIT = `SHAMT_WIDTH - 1 - i;
		localparam int DIST    = 1 << AMT_BIT;

		assign stage_data[i+1] = shamt[AMT_BIT] ?
			{{DIST{fill_bit}}, stage_data[i][`DATA_WIDTH-1:DIST]} :
			stage_data[i];
	end

	// Non-shift opcodes leave a right-shift value here, result_select drops it
	assign shift_result = shift_left ?
		reverse_bits(stage_data[`SHAMT_WIDTH]) :
		stage_data[`SHAMT_WIDTH];

endmodule

// ==== rtl/axi_lite_pkg.sv ====
`include "alu_params.svh"

package axi_lite_pkg;

	// Response codes
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;

	// Write channel FSM
	typedef enum logic {
		WR_IDLE,
		WR_RESP
	} wr_state_t;

	// Read channel FSM
	typedef enum logic {
		RD_IDLE,
		RD_DATA
	} rd_state_t;

endpackage

// ==== rtl/alu_types_pkg.sv ====
`include "alu_params.svh"

package alu_types_pkg;

	// Operands and results
	typedef logic [`DATA_WIDTH-1:0] data_word_t;

	// Shift amount taken from operand B
	typedef logic [`SHAMT_WIDTH-1:0] shamt_t;

	// Operation codes with 10 to 15 left undefined
	typedef enum logic [3:0] {
		OP_SLL  = 4'd0,
		OP_SRL  = 4'd1,
		OP_SRA  = 4'd2,
		OP_ADD  = 4'd3,
		OP_SUB  = 4'd4,
		OP_AND  = 4'd5,
		OP_OR   = 4'd6,
		OP_XOR  = 4'd7,
		OP_SLT  = 4'd8,
		OP_SLTU = 4'd9
	} alu_op_t;

endpackage

// ==== include/alu_params.svh ====
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Datapath widths
`define DATA_WIDTH         32
`define SHAMT_WIDTH        5

// Register bus address width
`define AXI_ADDR_WIDTH     8

// Register map in byte offsets
`define REG_OPERAND_A      8'h00
`define REG_OPERAND_B      8'h04
`define REG_OPCODE         8'h08
`define REG_RESULT         8'h0C
`define REG_STATUS         8'h10

// Bit positions inside STATUS
`define STATUS_VALID_BIT   0
`define STATUS_ZERO_BIT    1
`define STATUS_NEG_BIT     2
`define STATUS_BAD_OP_BIT  3

`endif
